/* hw/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// instruction memory depth in words.
`define IMEM_WORDS 256
`define IMEM_AW $clog2(`IMEM_WORDS)

// data memory depth in words.
`define DMEM_WORDS 256
`define DMEM_AW $clog2(`DMEM_WORDS)

// stores at or above this byte address go to the output port.
`define IO_BASE 32'h0000_8000

// outputs the receiver can buffer, also the credit count after reset.
`define OUT_CREDITS 2

`endif

/* hw/cpu_pkg.sv */
package cpu_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b,
		OP_HALT  = 6'h3f  // not a MIPS opcode, ends the program.
	} opcode_e;

	typedef enum logic [5:0] {
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		funct_e      funct;
	} r_fields_s;

	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_fields_s;

	// one instruction word, seen as register or immediate format.
	typedef union packed {
		r_fields_s r_fields;
		i_fields_s i_fields;
	} instr_u;

	typedef struct packed {
		logic [31:0] pc_plus4;
		instr_u      instr;
		logic        valid;
	} if_id_s;

	typedef struct packed {
		logic        valid;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0]  dest;
		logic        reg_write;
		logic        mem_read;
		logic        mem_write;
		logic        halt;
	} ex_mem_s;

	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} wb_s;

endpackage

/* hw/alu.sv */
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
	input  alu_op_e     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic [31:0] result,
	output logic        equal
);

	logic [31:0] diff;
	logic        less;

	assign diff  = a - b;
	assign equal = (a == b);  // drives beq and bne.
	assign less  = $signed(a) < $signed(b);

	always_comb begin
		unique case (op)
			ALU_ADD: result = a + b;  // wraps, no overflow trap.
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = {31'd0, less};
			ALU_LUI: result = {b[15:0], 16'd0};
			default: result = '0;
		endcase
	end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	output logic [31:0] rs_data,
	output logic [31:0] rt_data,
	input  wb_s         wb
);

	logic [31:0] regs [32];

	// register 0 is hardwired to zero.
	assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.we && wb.addr != 5'd0) begin
			regs[wb.addr] <= wb.data;
		end
	end

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module fetch_stage import cpu_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                stall,
	input  logic                halt_seen,
	input  logic                branch_taken,
	input  logic [31:0]         branch_target,
	input  logic                prog_we,
	input  logic [`IMEM_AW-1:0] prog_addr,
	input  logic [31:0]         prog_data,
	output logic                halted,
	output if_id_s              if_id
);

	logic [31:0] imem [`IMEM_WORDS];
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic        running;
	instr_u      fetched;

	assign pc_plus4 = pc + 32'd4;
	assign next_pc  = branch_taken ? branch_target : pc_plus4;  // target follows the delay slot.
	assign fetched  = imem[pc[`IMEM_AW+1:2]];

	always_ff @(posedge clk) begin
		if (prog_we && !running) begin
			imem[prog_addr] <= prog_data;  // program load only while idle.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			halted  <= 1'b0;
			pc      <= '0;
		end else if (start) begin
			running <= 1'b1;
			halted  <= 1'b0;
			pc      <= '0;
		end else if (halt_seen) begin
			running <= 1'b0;
			halted  <= 1'b1;
		end else if (running && !stall) begin
			pc <= next_pc;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id.valid <= 1'b0;
		end else if (!stall) begin
			if_id.pc_plus4 <= pc_plus4;
			if_id.instr    <= fetched;
			if_id.valid    <= running && !halt_seen;  // nothing fetched past a halt.
		end
	end

endmodule

/* hw/decode_exec_stage.sv */
`timescale 1ns/100ps

module decode_exec_stage import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        stall,
	input  if_id_s      if_id,
	input  wb_s         wb,
	output logic [4:0]  rs_addr,
	output logic [4:0]  rt_addr,
	input  logic [31:0] rs_data,
	input  logic [31:0] rt_data,
	output logic        branch_taken,
	output logic [31:0] branch_target,
	output ex_mem_s     ex_mem
);

	instr_u      ins;
	alu_op_e     alu_op;
	logic        use_imm, zero_ext, reg_write, dest_rt;
	logic        mem_read, mem_write, is_beq, is_bne, is_j, is_halt;
	logic        live;
	logic        equal;
	logic [31:0] rs_val, rt_val;
	logic [31:0] imm32;
	logic [31:0] alu_b;
	logic [31:0] alu_result;

	assign ins     = if_id.instr;
	assign rs_addr = ins.i_fields.rs;
	assign rt_addr = ins.i_fields.rt;

	// write-back bypass covers the write landing this same cycle.
	assign rs_val = (wb.we && wb.addr != 5'd0 && wb.addr == rs_addr) ? wb.data : rs_data;
	assign rt_val = (wb.we && wb.addr != 5'd0 && wb.addr == rt_addr) ? wb.data : rt_data;

	always_comb begin
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		zero_ext  = 1'b0;
		reg_write = 1'b0;
		dest_rt   = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_beq    = 1'b0;
		is_bne    = 1'b0;
		is_j      = 1'b0;
		is_halt   = 1'b0;
		case (ins.i_fields.op)
			OP_RTYPE: begin
				reg_write = 1'b1;
				case (ins.r_fields.funct)
					F_ADDU:  alu_op = ALU_ADD;
					F_SUBU:  alu_op = ALU_SUB;
					F_AND:   alu_op = ALU_AND;
					F_OR:    alu_op = ALU_OR;
					F_SLT:   alu_op = ALU_SLT;
					default: reg_write = 1'b0;  // unknown funct acts as a nop.
				endcase
			end
			OP_ADDIU: {use_imm, reg_write, dest_rt} = 3'b111;
			OP_ORI: begin
				alu_op = ALU_OR;
				{use_imm, zero_ext, reg_write, dest_rt} = 4'b1111;
			end
			OP_LUI: begin
				alu_op = ALU_LUI;
				{use_imm, reg_write, dest_rt} = 3'b111;
			end
			OP_LW:   {use_imm, mem_read, reg_write, dest_rt} = 4'b1111;
			OP_SW:   {use_imm, mem_write} = 2'b11;
			OP_BEQ:  is_beq = 1'b1;
			OP_BNE:  is_bne = 1'b1;
			OP_J:    is_j = 1'b1;
			OP_HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

	assign imm32 = zero_ext ? {16'd0, ins.i_fields.imm16}
	                        : {{16{ins.i_fields.imm16[15]}}, ins.i_fields.imm16};
	assign alu_b = use_imm ? imm32 : rt_val;

	alu u_alu (
		.op(alu_op),
		.a(rs_val),
		.b(alu_b),
		.result(alu_result),
		.equal(equal)
	);

	// anything behind a retiring halt is dropped.
	assign live = if_id.valid && !(ex_mem.valid && ex_mem.halt);

	assign branch_taken  = live && (is_j || (is_beq && equal) || (is_bne && !equal));
	assign branch_target = is_j ? {if_id.pc_plus4[31:23], ins.i_fields.rt, ins.i_fields.imm16, 2'b00}
	                            : if_id.pc_plus4 + {imm32[29:0], 2'b00};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem.valid <= 1'b0;
		end else if (!stall) begin
			ex_mem.valid      <= live;
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= rt_val;
			ex_mem.dest       <= dest_rt ? ins.i_fields.rt : ins.r_fields.rd;
			ex_mem.reg_write  <= reg_write;
			ex_mem.mem_read   <= mem_read;
			ex_mem.mem_write  <= mem_write;
			ex_mem.halt       <= is_halt;
		end
	end

endmodule

/* hw/mem_wb_stage.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module mem_wb_stage import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  ex_mem_s     ex_mem,
	input  logic        out_credit,
	output logic        out_valid,
	output logic [31:0] out_data,
	output logic        stall,
	output logic        halt_seen,
	output wb_s         wb
);

	logic [31:0]                          dmem [`DMEM_WORDS];
	logic [$clog2(`OUT_CREDITS+1)-1:0]    credits;
	logic [`DMEM_AW-1:0]                  word_addr;
	logic                                 is_io;
	logic                                 io_store;
	logic                                 have_credit;

	assign word_addr   = ex_mem.alu_result[`DMEM_AW+1:2];
	assign is_io       = ex_mem.alu_result >= `IO_BASE;
	assign io_store    = ex_mem.valid && ex_mem.mem_write && is_io;
	assign have_credit = (credits != '0);

	assign out_valid = io_store && have_credit;  // one pulse per store.
	assign out_data  = ex_mem.store_data;
	assign stall     = io_store && !have_credit;  // wait for the receiver.
	assign halt_seen = ex_mem.valid && ex_mem.halt;

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_write && !is_io) begin
			dmem[word_addr] <= ex_mem.store_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= `OUT_CREDITS;
		end else begin
			case ({out_valid, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // spent and returned in the same cycle.
			endcase
		end
	end

	assign wb.we   = ex_mem.valid && ex_mem.reg_write;
	assign wb.addr = ex_mem.dest;
	assign wb.data = ex_mem.mem_read ? dmem[word_addr] : ex_mem.alu_result;

endmodule

/* hw/cpu.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu import cpu_pkg::*; (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                prog_we,
	input  logic [`IMEM_AW-1:0] prog_addr,
	input  logic [31:0]         prog_data,
	input  logic                out_credit,
	output logic                out_valid,
	output logic [31:0]         out_data,
	output logic                halted
);

	if_id_s      if_id;
	ex_mem_s     ex_mem;
	wb_s         wb;
	logic        stall;
	logic        halt_seen;
	logic        branch_taken;
	logic [31:0] branch_target;
	logic [4:0]  rs_addr, rt_addr;
	logic [31:0] rs_data, rt_data;

	fetch_stage u_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.stall(stall),
		.halt_seen(halt_seen),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.halted(halted),
		.if_id(if_id)
	);

	reg_file u_rf (
		.clk(clk),
		.arst_n(arst_n),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wb(wb)
	);

	decode_exec_stage u_dx (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.if_id(if_id),
		.wb(wb),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.ex_mem(ex_mem)
	);

	mem_wb_stage u_mw (
		.clk(clk),
		.arst_n(arst_n),
		.ex_mem(ex_mem),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_data(out_data),
		.stall(stall),
		.halt_seen(halt_seen),
		.wb(wb)
	);

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period.
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;  // released between clock edges.
	end

endmodule

/* testbench/cpu_assert.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_assert (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic out_valid,
	input logic out_credit,
	input logic halted
);

	int credits;  // receiver side view of the credit count.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= `OUT_CREDITS;
		end else begin
			credits <= credits - int'(out_valid) + int'(out_credit);
		end
	end

	credit_guard: assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> credits > 0)
		else $error("out_valid pulsed with no credit left");

	halt_hold: assert property (@(posedge clk) disable iff (!arst_n) $fell(halted) |-> $past(start))
		else $error("halted dropped without a start pulse");

	reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind cpu cpu_assert u_assert (
	.clk(clk),
	.arst_n(arst_n),
	.start(start),
	.out_valid(out_valid),
	.out_credit(out_credit),
	.halted(halted)
);

/* testbench/cpu_tb.sv */
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

	localparam int IO_REG = 30;  // holds the output port address.
	localparam logic [31:0] HALT_WORD = {OP_HALT, 26'd0};

	logic                clk, arst_n;
	logic                start, prog_we;
	logic [`IMEM_AW-1:0] prog_addr;
	logic [31:0]         prog_data;
	logic                out_credit = 1'b0;
	logic                out_valid, halted;
	logic [31:0]         out_data;

	logic [31:0] prog[$];
	logic [31:0] expected[$];
	logic [31:0] observed[$];
	int          owed = 0;  // credits not yet handed back.
	bit          withhold = 1'b0;

	clock_gen u_clk (.clk(clk), .arst_n(arst_n));

	cpu DUT (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_data(out_data),
		.halted(halted)
	);

	// argument order follows the assembly form addu rd, rs, rt.
	function automatic logic [31:0] encode_r(funct_e f, int rd, int rs, int rt);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, f};
	endfunction

	// argument order follows addiu rt, rs, imm, so branches pass rt first.
	function automatic logic [31:0] encode_i(opcode_e op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] encode_j(int index);
		return {OP_J, index[25:0]};
	endfunction

	function automatic logic [31:0] store_out(int r);
		return encode_i(OP_SW, r, IO_REG, 0);
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge clk) begin
		if (arst_n && out_valid) begin
			observed.push_back(out_data);
			owed++;
		end
	end

	always @(negedge clk) begin
		if (owed > 0 && !withhold) begin
			out_credit = 1'b1;  // one credit back per cycle.
			owed--;
		end else begin
			out_credit = 1'b0;
		end
	end

	task automatic run_test(input string name, input bit hold_credits);
		int n;
		prog.push_front(encode_i(OP_ORI, IO_REG, 0, `IO_BASE));  // program starts at word 1.
		prog.push_back(HALT_WORD);
		prog.push_back(32'd0);
		foreach (prog[i]) begin
			@(negedge clk);
			prog_we   = 1'b1;
			prog_addr = i[`IMEM_AW-1:0];
			prog_data = prog[i];
		end
		@(negedge clk);
		prog_we  = 1'b0;
		observed.delete();
		withhold = hold_credits;
		start    = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (hold_credits) begin
			repeat (40) @(negedge clk);  // receiver stays full for a while.
			assert (observed.size() <= `OUT_CREDITS && halted === 1'b0)
				else report_failure($sformatf("%s: outputs ran past the withheld credits", name));
			withhold = 1'b0;
		end
		for (n = 0; n < 2000 && halted !== 1'b1; n++) @(negedge clk);
		if (halted !== 1'b1) report_failure($sformatf("%s: timeout waiting for halted", name));
		assert (observed.size() == expected.size())
			else report_failure($sformatf("mismatch at %0t: %s out_data count got %0d expected %0d",
				$time, name, observed.size(), expected.size()));
		foreach (expected[i]) begin
			assert (observed[i] === expected[i])
				else report_failure($sformatf("mismatch at %0t: %s out_data[%0d] got %h expected %h",
					$time, name, i, observed[i], expected[i]));
		end
		for (n = 0; n < 20 && owed != 0; n++) @(negedge clk);
		assert (observed.size() == expected.size())
			else report_failure($sformatf("%s: out_valid pulsed after halted rose", name));
	endtask

	task automatic test_arith();
		prog = '{
			encode_i(OP_ADDIU, 1, 0, 7),
			encode_i(OP_ADDIU, 2, 0, -12),
			encode_r(F_ADDU, 3, 1, 2),
			store_out(3),
			encode_r(F_SUBU, 4, 1, 2),
			store_out(4),
			encode_r(F_AND, 5, 1, 2),
			store_out(5),
			encode_r(F_OR, 6, 1, 2),
			store_out(6),
			encode_r(F_SLT, 7, 2, 1),
			store_out(7),
			encode_r(F_SLT, 8, 1, 2),
			store_out(8),
			encode_i(OP_LUI, 9, 0, 'h7fff),
			encode_i(OP_ORI, 9, 9, 'hffff),
			encode_i(OP_ADDIU, 10, 9, 1),  // wraps to the most negative value.
			store_out(10)
		};
		expected = '{32'hffff_fffb, 32'd19, 32'd4, 32'hffff_fff7, 32'd1, 32'd0, 32'h8000_0000};
		run_test("arith", 1'b0);
	endtask

	task automatic test_immediates();
		prog = '{
			encode_i(OP_LUI, 1, 0, 'h1234),
			encode_i(OP_ORI, 1, 1, 'habcd),
			store_out(1),
			encode_i(OP_ORI, 2, 0, 'hffff),
			store_out(2),
			encode_i(OP_ADDIU, 0, 0, 5),
			store_out(0)
		};
		expected = '{32'h1234_abcd, 32'h0000_ffff, 32'd0};
		run_test("immediates", 1'b0);
	endtask

	task automatic test_memory();
		prog = '{
			encode_i(OP_ADDIU, 1, 0, -100),
			encode_i(OP_LUI, 2, 0, 'hcafe),
			encode_i(OP_ORI, 2, 2, 'hf00d),
			encode_i(OP_SW, 1, 0, 16),
			encode_i(OP_SW, 2, 0, 20),
			encode_i(OP_LW, 3, 0, 16),
			store_out(3),
			encode_i(OP_LW, 4, 0, 20),
			encode_r(F_ADDU, 5, 4, 1),
			store_out(4),
			store_out(5)
		};
		expected = '{32'hffff_ff9c, 32'hcafe_f00d, 32'hcafe_efa9};
		run_test("memory", 1'b0);
	endtask

	task automatic test_control_flow();
		prog = '{
			encode_i(OP_ADDIU, 1, 0, 3),
			encode_r(F_ADDU, 12, 0, 0),
			store_out(1),
			encode_i(OP_ADDIU, 1, 1, -1),
			encode_i(OP_BNE, 0, 1, -3),
			encode_i(OP_ADDIU, 12, 12, 1),  // delay slot, runs every pass.
			store_out(12),
			encode_i(OP_BEQ, 0, 0, 2),
			encode_i(OP_ADDIU, 3, 0, 'h55),
			encode_i(OP_ADDIU, 3, 0, 'h66),
			store_out(3),
			encode_j(15),
			encode_i(OP_ADDIU, 4, 0, 'h77),
			encode_i(OP_ADDIU, 4, 0, 'h88),
			store_out(4)
		};
		expected = '{32'd3, 32'd2, 32'd1, 32'd3, 32'h55, 32'h77};
		run_test("control_flow", 1'b0);
	endtask

	task automatic test_credit_backpressure();
		prog.delete();
		expected.delete();
		prog.push_back(encode_r(F_ADDU, 1, 0, 0));
		for (int i = 1; i <= 5; i++) begin
			prog.push_back(encode_i(OP_ADDIU, 1, 1, 10));
			prog.push_back(store_out(1));
			expected.push_back(32'(10 * i));
		end
		run_test("credit_backpressure", 1'b1);
	endtask

	initial begin
		int n;
		start     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		for (n = 0; n < 50 && arst_n !== 1'b1; n++) @(negedge clk);
		if (arst_n !== 1'b1) report_failure("reset was never released");
		test_arith();
		test_immediates();
		test_memory();
		test_control_flow();
		test_credit_backpressure();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* flist.f */
+incdir+hw
hw/cpu_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_exec_stage.sv
hw/mem_wb_stage.sv
hw/cpu.sv
testbench/clock_gen.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv

/* Makefile */
# Verilator simulation of the pipelined cpu with its testbench.

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f flist.f -o cpu_sim
	./obj_dir/cpu_sim | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
